//--- exu_top.f
design/exu_pkg.sv
design/issue_queue.sv
design/alu.sv
design/branch_unit.sv
design/exu_result_reg.sv
design/exu_top.sv
test/tb_exu_top.sv

//--- test/tb_exu_top.sv
`timescale 1ns/1ps

module tb_exu_top;

	localparam int queue_depth = 2;
	localparam int drive_dly   = 2;
	localparam int n_alu       = 36;
	localparam int n_ctrl      = 28;
	localparam int n_mem_csr   = 6;
	localparam int n_bp        = 40;
	localparam int n_tp        = 16;
	localparam int cycle_limit = (n_alu + n_ctrl + n_mem_csr + n_bp + n_tp) * 4 + 200;

	logic               clock;
	logic               rst_n;
	logic               in_valid;
	logic               in_ready;
	logic               out_valid;
	logic               out_ready;
	exu_pkg::exu_req_t  in_req;
	exu_pkg::exu_resp_t out_resp;

	exu_pkg::exu_resp_t exp_q [$];   // accepted, not yet delivered
	int                 out_edges [$];
	exu_pkg::exu_resp_t mon_exp;
	integer             seed = 78089;
	integer             ready_seed;
	logic [31:0]        ready_draw;
	logic               random_ready;
	int                 cycle = 0;
	int                 last_accept;

	exu_top #(
		.queue_depth(queue_depth)
	) uut (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_req    (in_req),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_resp  (out_resp),
		.out_ready (out_ready)
	);

	always #20 clock = ~clock;

	always @(posedge clock) begin
		cycle = cycle + 1;
		if (cycle > cycle_limit) begin
			$display("run timed out after %0d cycles", cycle_limit);
			halt_failed();
		end
	end

	// lsu side ready, random only while back-pressure runs
	always @(posedge clock) begin
		#(drive_dly);
		if (random_ready) begin
			ready_draw = $random(ready_seed);
			out_ready  = ready_draw[0];
		end else begin
			out_ready = 1'b1;
		end
	end

	// transfer happens at the next rising edge
	always @(negedge clock) begin
		if (rst_n) begin
			if (!in_ready && exp_q.size() != queue_depth + 1) begin
				$display("in_ready low with %0d pending, full means %0d", exp_q.size(),
					queue_depth + 1);
				halt_failed();
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					$display("response delivered with nothing pending");
					halt_failed();
				end
				mon_exp = exp_q.pop_front();
				compare_resp(mon_exp, out_resp);
				out_edges.push_back(cycle + 1);
			end
		end
	end

	task automatic halt_failed();
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic compare_word(input string name, input exu_pkg::word_t exp,
		input exu_pkg::word_t act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %h got %h", name, exp, act);
			halt_failed();
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %h got %h", name, exp, act);
			halt_failed();
		end
	endtask

	task automatic compare_resp(input exu_pkg::exu_resp_t exp, input exu_pkg::exu_resp_t act);
		compare_word("rd", {28'b0, exp.rd}, {28'b0, act.rd});
		compare_word("val", exp.val, act.val);
		compare_word("lsu_data", exp.lsu_data, act.lsu_data);
		compare_word("funct3", {29'b0, exp.funct3}, {29'b0, act.funct3});
		compare_bit("reg_wen", exp.reg_wen, act.reg_wen);
		compare_bit("lsu_ren", exp.lsu_ren, act.lsu_ren);
		compare_bit("lsu_wen", exp.lsu_wen, act.lsu_wen);
		compare_word("jump_addr", exp.jump_addr, act.jump_addr);
		compare_bit("jump_wrong", exp.jump_wrong, act.jump_wrong);
		compare_word("csr_wdata", exp.csr_wdata, act.csr_wdata);
		compare_bit("csr_enable", exp.csr_enable, act.csr_enable);
	endtask

	function automatic exu_pkg::exu_resp_t model_resp(input exu_pkg::exu_req_t r);
		exu_pkg::exu_resp_t e;
		exu_pkg::word_t     b;
		logic [4:0]         sh;
		logic               take;
		e          = '0;
		e.rd       = r.rd;
		e.funct3   = r.funct3;
		e.reg_wen  = r.reg_wen;
		e.lsu_data = r.src2;
		e.lsu_ren  = (r.op_class == exu_pkg::op_load);
		e.lsu_wen  = (r.op_class == exu_pkg::op_store);
		b  = (r.op_class == exu_pkg::op_reg) ? r.src2 : r.imm;
		sh = b[4:0];
		case (r.op_class)
			exu_pkg::op_lui:    e.val = r.imm;
			exu_pkg::op_auipc,
			exu_pkg::op_branch: e.val = r.pc + r.imm;
			exu_pkg::op_jal,
			exu_pkg::op_jalr:   e.val = r.pc + 32'd4;
			exu_pkg::op_csr:    e.val = r.csr_val;
			exu_pkg::op_imm,
			exu_pkg::op_reg: begin
				case (r.funct3)
					3'd0: begin
						if (r.op_class == exu_pkg::op_reg && r.funct7_5)
							e.val = r.src1 - b;
						else
							e.val = r.src1 + b;
					end
					3'd1: e.val = r.src1 << sh;
					3'd2: e.val = ($signed(r.src1) < $signed(b)) ? 32'd1 : 32'd0;
					3'd3: e.val = (r.src1 < b) ? 32'd1 : 32'd0;
					3'd4: e.val = r.src1 ^ b;
					3'd5: begin
						if (r.funct7_5)
							e.val = $signed(r.src1) >>> sh;
						else
							e.val = r.src1 >> sh;
					end
					3'd6: e.val = r.src1 | b;
					default: e.val = r.src1 & b;
				endcase
			end
			default: e.val = r.src1 + r.imm; // load and store address
		endcase
		case (r.funct3)
			3'b000:  take = (r.src1 == r.src2);
			3'b001:  take = (r.src1 != r.src2);
			3'b100:  take = ($signed(r.src1) < $signed(r.src2));
			3'b101:  take = !($signed(r.src1) < $signed(r.src2));
			3'b110:  take = (r.src1 < r.src2);
			3'b111:  take = !(r.src1 < r.src2);
			default: take = 1'b0;
		endcase
		if (r.csr_jump_en)
			e.jump_addr = r.csr_jump;
		else if (r.op_class == exu_pkg::op_jal || (r.op_class == exu_pkg::op_branch && take))
			e.jump_addr = r.pc + r.imm;
		else if (r.op_class == exu_pkg::op_jalr)
			e.jump_addr = r.src1 + r.imm;
		else
			e.jump_addr = r.pc + 32'd4;
		e.jump_wrong = (e.jump_addr != r.dnpc);
		e.csr_enable = (r.op_class == exu_pkg::op_csr) && (r.funct3 != 3'b000);
		if (r.funct3 == 3'b001)
			e.csr_wdata = r.src1;
		else if (r.funct3 == 3'b010)
			e.csr_wdata = r.src1 | r.csr_val;
		return e;
	endfunction

	function automatic exu_pkg::exu_req_t rand_req(input exu_pkg::op_class_t cls);
		exu_pkg::exu_req_t r;
		logic [31:0]       t;
		r          = '0;
		r.op_class = cls;
		t          = $random(seed);
		r.rd       = t[3:0];
		r.funct3   = t[6:4];
		r.funct7_5 = t[7];
		r.reg_wen  = t[8];
		r.src1     = $random(seed);
		r.src2     = $random(seed);
		r.imm      = $random(seed);
		r.csr_val  = $random(seed);
		r.csr_jump = $random(seed);
		t          = $random(seed);
		r.pc       = {t[31:2], 2'b00};
		r.dnpc     = r.pc + 32'd4; // sequential guess
		return r;
	endfunction

	task automatic push_req(input exu_pkg::exu_req_t r);
		logic accepted;
		in_valid = 1'b1;
		in_req   = r;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clock);
			accepted = in_ready;
			@(posedge clock);
			#(drive_dly);
		end
		in_valid    = 1'b0;
		last_accept = cycle;
		exp_q.push_back(model_resp(r));
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			@(posedge clock);
		#(drive_dly);
	endtask

	task automatic set_ready_mode(input logic random_on);
		@(negedge clock);
		random_ready = random_on;
		@(posedge clock);
		#(drive_dly);
	endtask

	task automatic check_reset();
		compare_bit("out_valid", 1'b0, out_valid);
		compare_bit("in_ready", 1'b1, in_ready);
		compare_bit("out_resp.jump_wrong", 1'b0, out_resp.jump_wrong);
	endtask

	task automatic run_alu();
		exu_pkg::exu_req_t r;
		int                c;
		int                f;
		int                s;
		for (c = 0; c < 2; c++)
			for (f = 0; f < 8; f++)
				for (s = 0; s < 2; s++) begin
					r          = rand_req(c == 0 ? exu_pkg::op_reg : exu_pkg::op_imm);
					r.funct3   = f[2:0];
					r.funct7_5 = s[0];
					push_req(r);
				end
		for (c = 0; c < 2; c++) begin
			push_req(rand_req(exu_pkg::op_lui));
			push_req(rand_req(exu_pkg::op_auipc));
		end
		drain();
	endtask

	task automatic run_control();
		exu_pkg::exu_req_t r;
		exu_pkg::word_t    base;
		int                f;
		int                k;
		for (f = 0; f < 8; f++)
			for (k = 0; k < 3; k++) begin
				r        = rand_req(exu_pkg::op_branch);
				r.funct3 = f[2:0];
				base     = {2'b00, r.src1[29:0]};
				r.src1   = (k == 2) ? base + 32'd100 : base; // equal, less, greater
				r.src2   = (k == 1) ? base + 32'd100 : base;
				push_req(r);
			end
		r      = rand_req(exu_pkg::op_jal);
		r.dnpc = r.pc + r.imm;
		push_req(r);
		r.dnpc = r.pc + r.imm + 32'd8;
		push_req(r);
		r      = rand_req(exu_pkg::op_jalr);
		r.dnpc = r.src1 + r.imm;
		push_req(r);
		r.dnpc = r.src1 + r.imm + 32'd8;
		push_req(r);
		drain();
	endtask

	task automatic run_mem_csr();
		exu_pkg::exu_req_t r;
		push_req(rand_req(exu_pkg::op_load));
		push_req(rand_req(exu_pkg::op_store));
		r        = rand_req(exu_pkg::op_csr);
		r.funct3 = 3'b001; // csrrw
		push_req(r);
		r.funct3 = 3'b010; // csrrs
		push_req(r);
		r.funct3 = 3'b000;
		push_req(r);
		r             = rand_req(exu_pkg::op_jal);
		r.csr_jump_en = 1'b1;
		r.dnpc        = r.csr_jump;
		push_req(r);
		drain();
	endtask

	task automatic run_backpressure();
		exu_pkg::exu_req_t batch [n_bp];
		logic [31:0]       sel;
		logic [3:0]        cls_bits;
		int                i;
		for (i = 0; i < n_bp; i++) begin
			sel      = $random(seed);
			cls_bits = 4'(sel % 10);
			batch[i] = rand_req(exu_pkg::op_class_t'(cls_bits));
		end
		ready_seed = seed;
		set_ready_mode(1'b1);
		for (i = 0; i < n_bp; i++)
			push_req(batch[i]);
		drain();
		set_ready_mode(1'b0);
	endtask

	task automatic run_throughput();
		int i;
		int first;
		out_edges.delete();
		first = 0;
		for (i = 0; i < n_tp; i++) begin
			push_req(rand_req(exu_pkg::op_imm));
			if (i == 0)
				first = last_accept;
		end
		drain();
		if (out_edges.size() != n_tp) begin
			$display("throughput stream delivered %0d responses instead of %0d",
				out_edges.size(), n_tp);
			halt_failed();
		end
		// first result two edges after acceptance, then one per edge
		for (i = 0; i < n_tp; i++)
			compare_word("out_valid edge", first + 2 + i, out_edges[i]);
	endtask

	initial begin
		clock        = 1'b0;
		rst_n        = 1'b0;
		in_valid     = 1'b0;
		in_req       = '0;
		out_ready    = 1'b1;
		random_ready = 1'b0;
		ready_seed   = seed;
		repeat (4) @(posedge clock);
		#(drive_dly);
		rst_n = 1'b1;
		@(posedge clock);
		#(drive_dly);
		check_reset();
		run_alu();
		run_control();
		run_mem_csr();
		run_backpressure();
		run_throughput();
		repeat (4) @(posedge clock);
		if (exp_q.size() == 0 && !out_valid) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("responses still pending at end of run");
			halt_failed();
		end
	end

endmodule

//--- design/exu_top.sv
`timescale 1ns/1ps

module exu_top #(
	parameter int queue_depth = 2
) (
	input  logic               clock,
	input  logic               rst_n,

	input  logic               in_valid,
	input  exu_pkg::exu_req_t  in_req,
	output logic               in_ready,

	output logic               out_valid,
	output exu_pkg::exu_resp_t out_resp,
	input  logic               out_ready
);

	logic              head_valid;
	logic              head_ready;
	exu_pkg::exu_req_t head_req;
	exu_pkg::word_t    alu_result;
	exu_pkg::word_t    jump_addr;
	logic              jump_wrong;

	issue_queue #(
		.queue_depth(queue_depth)
	) u_queue (
		.clock      (clock),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_req     (in_req),
		.in_ready   (in_ready),
		.head_valid (head_valid),
		.head_req   (head_req),
		.head_ready (head_ready)
	);

	alu u_alu (
		.req    (head_req),
		.result (alu_result)
	);

	branch_unit u_bru (
		.req        (head_req),
		.jump_addr  (jump_addr),
		.jump_wrong (jump_wrong)
	);

	exu_result_reg u_result (
		.clock      (clock),
		.rst_n      (rst_n),
		.head_valid (head_valid),
		.head_req   (head_req),
		.head_ready (head_ready),
		.alu_result (alu_result),
		.jump_addr  (jump_addr),
		.jump_wrong (jump_wrong),
		.out_valid  (out_valid),
		.out_resp   (out_resp),
		.out_ready  (out_ready)
	);

endmodule

//--- design/exu_result_reg.sv
`timescale 1ns/1ps

module exu_result_reg (
	input  logic               clock,
	input  logic               rst_n,

	input  logic               head_valid,
	input  exu_pkg::exu_req_t  head_req,
	output logic               head_ready,

	input  exu_pkg::word_t     alu_result,
	input  exu_pkg::word_t     jump_addr,
	input  logic               jump_wrong,

	output logic               out_valid,
	output exu_pkg::exu_resp_t out_resp,
	input  logic               out_ready
);

	exu_pkg::exu_resp_t resp_d;
	exu_pkg::exu_resp_t resp_q;
	logic               capture;

	// empty, or current content leaves this cycle
	assign head_ready = ~out_valid | out_ready;
	assign capture    = head_valid & head_ready;

	always_comb begin
		resp_d            = '0;
		resp_d.rd         = head_req.rd;
		resp_d.val        = alu_result;
		resp_d.lsu_data   = head_req.src2; // store data
		resp_d.funct3     = head_req.funct3;
		resp_d.reg_wen    = head_req.reg_wen;
		resp_d.lsu_ren    = (head_req.op_class == exu_pkg::op_load);
		resp_d.lsu_wen    = (head_req.op_class == exu_pkg::op_store);
		resp_d.jump_addr  = jump_addr;
		resp_d.jump_wrong = jump_wrong;
		resp_d.csr_enable = (head_req.op_class == exu_pkg::op_csr) && (head_req.funct3 != '0);
		case (head_req.funct3)
			exu_pkg::f3_csrrw: resp_d.csr_wdata = head_req.src1;
			exu_pkg::f3_csrrs: resp_d.csr_wdata = head_req.src1 | head_req.csr_val;
			default:           resp_d.csr_wdata = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (capture)
			resp_q <= resp_d;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			if (capture)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	always_comb begin
		out_resp            = resp_q;
		out_resp.jump_wrong = resp_q.jump_wrong & out_valid; // flag only lives with its response
	end

	// lsu side must see a steady word until it takes it
	assert property (@(posedge clock) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_resp));

endmodule

//--- design/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
	input  exu_pkg::exu_req_t req,
	output exu_pkg::word_t    jump_addr,
	output logic              jump_wrong
);

	logic           cond;
	logic           is_jal;
	logic           is_jalr;
	logic           is_branch;
	logic           taken;
	exu_pkg::word_t target;
	exu_pkg::word_t snpc;

	assign is_jal    = (req.op_class == exu_pkg::op_jal);
	assign is_jalr   = (req.op_class == exu_pkg::op_jalr);
	assign is_branch = (req.op_class == exu_pkg::op_branch);

	always_comb begin
		case (req.funct3)
			exu_pkg::f3_beq:  cond = (req.src1 == req.src2);
			exu_pkg::f3_bne:  cond = (req.src1 != req.src2);
			exu_pkg::f3_blt:  cond = ($signed(req.src1) < $signed(req.src2));
			exu_pkg::f3_bge:  cond = ($signed(req.src1) >= $signed(req.src2));
			exu_pkg::f3_bltu: cond = (req.src1 < req.src2);
			exu_pkg::f3_bgeu: cond = (req.src1 >= req.src2);
			default:          cond = 1'b0; // reserved codes fall through
		endcase
	end

	assign taken  = is_jal | is_jalr | (is_branch & cond);
	assign target = is_jalr ? (req.src1 + req.imm) : (req.pc + req.imm);
	assign snpc   = req.pc + exu_pkg::inst_bytes;

	// csr redirect wins over everything
	always_comb begin
		if (req.csr_jump_en)
			jump_addr = req.csr_jump;
		else if (taken)
			jump_addr = target;
		else
			jump_addr = snpc;
	end

	assign jump_wrong = (jump_addr != req.dnpc); // decode guessed wrong

endmodule

//--- design/alu.sv
`timescale 1ns/1ps

module alu (
	input  exu_pkg::exu_req_t req,
	output exu_pkg::word_t    result
);

	exu_pkg::word_t   lop;
	exu_pkg::word_t   rop;
	exu_pkg::word_t   op_out;
	exu_pkg::alu_op_t op;
	logic [4:0]       shamt;
	logic             arith;

	assign arith = (req.op_class == exu_pkg::op_imm) || (req.op_class == exu_pkg::op_reg);
	assign shamt = rop[4:0];

	always_comb begin
		case (req.op_class)
			exu_pkg::op_auipc,
			exu_pkg::op_jal,
			exu_pkg::op_branch: lop = req.pc;
			exu_pkg::op_lui:    lop = '0;
			default:            lop = req.src1; // imm, reg, jalr, load, store
		endcase
	end

	assign rop = (req.op_class == exu_pkg::op_reg) ? req.src2 : req.imm;

	// only register and immediate ops decode funct3
	always_comb begin
		op = exu_pkg::alu_add;
		if (arith) begin
			case (req.funct3)
				3'b000: begin
					if (req.op_class == exu_pkg::op_reg && req.funct7_5)
						op = exu_pkg::alu_sub;
					else
						op = exu_pkg::alu_add;
				end
				3'b001: op = exu_pkg::alu_sll;
				3'b010: op = exu_pkg::alu_slt;
				3'b011: op = exu_pkg::alu_sltu;
				3'b100: op = exu_pkg::alu_xor;
				3'b101: begin
					if (req.funct7_5)
						op = exu_pkg::alu_sra;
					else
						op = exu_pkg::alu_srl;
				end
				3'b110: op = exu_pkg::alu_or;
				default: op = exu_pkg::alu_and;
			endcase
		end
	end

	always_comb begin
		case (op)
			exu_pkg::alu_sub:  op_out = lop - rop;
			exu_pkg::alu_and:  op_out = lop & rop;
			exu_pkg::alu_xor:  op_out = lop ^ rop;
			exu_pkg::alu_or:   op_out = lop | rop;
			exu_pkg::alu_srl:  op_out = lop >> shamt;
			exu_pkg::alu_sra:  op_out = $signed(lop) >>> shamt;
			exu_pkg::alu_sll:  op_out = lop << shamt;
			exu_pkg::alu_slt:  op_out = {31'b0, $signed(lop) < $signed(rop)};
			exu_pkg::alu_sltu: op_out = {31'b0, lop < rop};
			default:           op_out = lop + rop; // add, addresses, targets
		endcase
	end

	always_comb begin
		case (req.op_class)
			exu_pkg::op_jal,
			exu_pkg::op_jalr: result = req.pc + exu_pkg::inst_bytes; // link value
			exu_pkg::op_csr:  result = req.csr_val;
			default:          result = op_out;
		endcase
	end

endmodule

//--- design/issue_queue.sv
`timescale 1ns/1ps

module issue_queue #(
	parameter int queue_depth = 2
) (
	input  logic              clock,
	input  logic              rst_n,

	input  logic              in_valid,
	input  exu_pkg::exu_req_t in_req,
	output logic              in_ready,

	output logic              head_valid,
	output exu_pkg::exu_req_t head_req,
	input  logic              head_ready
);

	localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int cnt_w = $clog2(queue_depth + 1);

	exu_pkg::exu_req_t mem [queue_depth];

	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	logic [cnt_w-1:0] count;
	logic             push;
	logic             pop;

	// wraps at depth, so non power of two depths work too
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		return (ptr == ptr_w'(queue_depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign in_ready   = (count != cnt_w'(queue_depth));
	assign head_valid = (count != '0);
	assign head_req   = mem[rd_ptr];

	assign push = in_valid & in_ready;
	assign pop  = head_valid & head_ready;

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= in_req;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // none or both
			endcase
		end
	end

	// never more entries than slots
	assert property (@(posedge clock) disable iff (!rst_n)
		count <= cnt_w'(queue_depth));

	// pointers meet exactly when empty or full
	assert property (@(posedge clock) disable iff (!rst_n)
		(rd_ptr == wr_ptr) == (count == '0 || count == cnt_w'(queue_depth)));

endmodule

//--- design/exu_pkg.sv
package exu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  reg_idx_t; // rv32e, 16 regs
	typedef logic [2:0]  funct3_t;

	// instruction class as seen by execute
	typedef enum logic [3:0] {
		op_lui,
		op_auipc,
		op_jal,
		op_jalr,
		op_branch,
		op_load,
		op_store,
		op_imm,
		op_reg,
		op_csr
	} op_class_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_xor,
		alu_or,
		alu_srl,
		alu_sra,
		alu_sll,
		alu_slt,
		alu_sltu
	} alu_op_t;

	localparam word_t inst_bytes = 32'd4; // pc step

	// branch conditions
	localparam funct3_t f3_beq  = 3'b000;
	localparam funct3_t f3_bne  = 3'b001;
	localparam funct3_t f3_blt  = 3'b100;
	localparam funct3_t f3_bge  = 3'b101;
	localparam funct3_t f3_bltu = 3'b110;
	localparam funct3_t f3_bgeu = 3'b111;

	localparam funct3_t f3_csrrw = 3'b001;
	localparam funct3_t f3_csrrs = 3'b010;

	typedef struct packed {
		op_class_t op_class;
		reg_idx_t  rd;
		word_t     src1;
		word_t     src2;
		word_t     imm;
		funct3_t   funct3;
		logic      funct7_5;
		word_t     pc;
		word_t     dnpc;        // predicted next pc
		logic      reg_wen;
		logic      csr_jump_en;
		word_t     csr_jump;    // trap / return target
		word_t     csr_val;
	} exu_req_t;

	typedef struct packed {
		reg_idx_t rd;
		word_t    val;
		word_t    lsu_data;
		funct3_t  funct3;
		logic     reg_wen;
		logic     lsu_ren;
		logic     lsu_wen;
		word_t    jump_addr;
		logic     jump_wrong;
		word_t    csr_wdata;
		logic     csr_enable;
	} exu_resp_t;

endpackage
